//--- hdl/mazePkg.sv
`default_nettype none

package mazePkg;

    // controller states
    typedef enum logic [4:0] {
        IDLE         = 5'd0,
        START        = 5'd1,
        COUNT        = 5'd2,
        STRAIGHT     = 5'd3,
        LITTLE_LEFT  = 5'd4,
        LITTLE_RIGHT = 5'd5,
        CHOOSE       = 5'd6,
        LEFT         = 5'd7,
        RIGHT        = 5'd8,
        BACK         = 5'd9,
        STOP         = 5'd10,
        FINISH       = 5'd11
    } carState_t;

    // sensor bits are left, mid, right; 1 means line seen
    typedef logic [2:0] track_t;

    localparam track_t OFF_ROAD         = 3'b000;
    localparam track_t ON_LINE          = 3'b010;
    localparam track_t DRIFT_RIGHT      = 3'b001;
    localparam track_t DRIFT_RIGHT_HARD = 3'b011;
    localparam track_t DRIFT_LEFT       = 3'b100;
    localparam track_t DRIFT_LEFT_HARD  = 3'b110;
    localparam track_t T_JUNCTION       = 3'b101;
    localparam track_t CROSSING         = 3'b111;

    typedef enum logic [1:0] {
        NONE        = 2'd0,
        GO_STRAIGHT = 2'd1,
        GO_LEFT     = 2'd2,
        GO_RIGHT    = 2'd3
    } decision_t;

    // push and pop together replace the top entry
    typedef struct packed {
        logic      push;
        logic      pop;
        decision_t value;
    } stackCmd_t;

    typedef struct packed {
        logic leftFwd;
        logic leftRev;
        logic rightFwd;
        logic rightRev;
        logic leftPwm;
        logic rightPwm;
    } wheelCmd_t;

    localparam int DEPTH_W = 5;
    typedef logic [DEPTH_W-1:0] depth_t;
    localparam depth_t STACK_DEPTH = 5'd16;

    localparam int TIMER_W = 8;
    typedef logic [TIMER_W-1:0] timerCount_t;
    localparam timerCount_t START_CYCLES = 8'd16;
    localparam timerCount_t STOP_CYCLES  = 8'd8;

    localparam int PWM_PERIOD = 16;
    localparam int PWM_W = $clog2(PWM_PERIOD);
    typedef logic [PWM_W-1:0] pwmCount_t;
    localparam pwmCount_t PWM_FULL = 4'd12;
    localparam pwmCount_t PWM_SLOW = 4'd6;

endpackage

`default_nettype wire

//--- hdl/phaseTimer.sv
`timescale 1ns/1ns
`default_nettype none

module phaseTimer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          timerLoad,
    input  wire mazePkg::timerCount_t    timerCycles,
    output logic                         timerDone
);

    mazePkg::timerCount_t count;

    // done rises exactly timerCycles cycles after the load cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            timerDone <= 1'b0;
        end else if (timerLoad) begin
            count <= (timerCycles == '0) ? '0 : timerCycles - 1'b1;
            timerDone <= (timerCycles == mazePkg::timerCount_t'(1));
        end else begin
            timerDone <= (count == mazePkg::timerCount_t'(1));
            if (count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    donePulse: assert property (@(posedge clk) disable iff (rst)
        timerDone |=> !timerDone)
        else $error("timer done held longer than one cycle");

endmodule

`default_nettype wire

//--- hdl/decisionStack.sv
`timescale 1ns/1ns
`default_nettype none

module decisionStack (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mazePkg::stackCmd_t   stackCmd,
    output mazePkg::decision_t        top,
    output mazePkg::depth_t           depth
);

    mazePkg::decision_t             mem [mazePkg::STACK_DEPTH];
    logic [mazePkg::DEPTH_W-2:0]    topIdx;
    logic                           doPush;
    logic                           doPop;
    logic                           doReplace;

    assign topIdx = depth[mazePkg::DEPTH_W-2:0] - 1'b1;

    // overflow and underflow are dropped
    assign doPush = stackCmd.push && !stackCmd.pop && depth != mazePkg::STACK_DEPTH;
    assign doPop = stackCmd.pop && !stackCmd.push && depth != '0;
    assign doReplace = stackCmd.push && stackCmd.pop && depth != '0;

    assign top = (depth == '0) ? mazePkg::NONE : mem[topIdx];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[depth[mazePkg::DEPTH_W-2:0]] <= stackCmd.value;
        end else if (doReplace) begin
            mem[topIdx] <= stackCmd.value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            depth <= '0;
        end else if (doPush) begin
            depth <= depth + 1'b1;
        end else if (doPop) begin
            depth <= depth - 1'b1;
        end
    end

    depthBound: assert property (@(posedge clk) disable iff (rst)
        depth <= mazePkg::STACK_DEPTH)
        else $error("stack depth %0d out of range", depth);

endmodule

`default_nettype wire

//--- hdl/motorDrive.sv
`timescale 1ns/1ns
`default_nettype none

module motorDrive (
    input  wire                       clk,
    input  wire                       rst,
    input  wire mazePkg::carState_t   state,
    output mazePkg::wheelCmd_t        wheels
);

    mazePkg::pwmCount_t pwmCount;
    mazePkg::pwmCount_t leftDuty;
    mazePkg::pwmCount_t rightDuty;

    // free-running PWM period
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCount <= '0;
        end else if (pwmCount == mazePkg::pwmCount_t'(mazePkg::PWM_PERIOD - 1)) begin
            pwmCount <= '0;
        end else begin
            pwmCount <= pwmCount + 1'b1;
        end
    end

    always_comb begin
        wheels = '0;
        leftDuty = '0;
        rightDuty = '0;
        case (state)
            mazePkg::STRAIGHT: begin
                wheels.leftFwd = 1'b1;
                wheels.rightFwd = 1'b1;
                leftDuty = mazePkg::PWM_FULL;
                rightDuty = mazePkg::PWM_FULL;
            end
            // inner wheel slows down for small corrections
            mazePkg::LITTLE_LEFT: begin
                wheels.leftFwd = 1'b1;
                wheels.rightFwd = 1'b1;
                leftDuty = mazePkg::PWM_SLOW;
                rightDuty = mazePkg::PWM_FULL;
            end
            mazePkg::LITTLE_RIGHT: begin
                wheels.leftFwd = 1'b1;
                wheels.rightFwd = 1'b1;
                leftDuty = mazePkg::PWM_FULL;
                rightDuty = mazePkg::PWM_SLOW;
            end
            // spin on the spot for wide turns
            mazePkg::LEFT: begin
                wheels.leftRev = 1'b1;
                wheels.rightFwd = 1'b1;
                leftDuty = mazePkg::PWM_FULL;
                rightDuty = mazePkg::PWM_FULL;
            end
            mazePkg::RIGHT: begin
                wheels.leftFwd = 1'b1;
                wheels.rightRev = 1'b1;
                leftDuty = mazePkg::PWM_FULL;
                rightDuty = mazePkg::PWM_FULL;
            end
            mazePkg::BACK: begin
                wheels.leftRev = 1'b1;
                wheels.rightRev = 1'b1;
                leftDuty = mazePkg::PWM_FULL;
                rightDuty = mazePkg::PWM_FULL;
            end
            default: begin
                wheels = '0;
            end
        endcase
        wheels.leftPwm = pwmCount < leftDuty;
        wheels.rightPwm = pwmCount < rightDuty;
    end

endmodule

`default_nettype wire

//--- hdl/routeFsm.sv
`timescale 1ns/1ns
`default_nettype none

module routeFsm (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       enable,
    input  wire                       obstacle,
    input  wire mazePkg::track_t      track,
    input  wire mazePkg::decision_t   top,
    input  wire                       timerDone,
    output mazePkg::carState_t        state,
    output mazePkg::stackCmd_t        stackCmd,
    output logic                      timerLoad,
    output mazePkg::timerCount_t      timerCycles
);

    mazePkg::carState_t stateNext;
    mazePkg::carState_t resumeState;
    mazePkg::carState_t resumeNext;
    logic               seen;
    logic               seenSet;
    logic               groupChange;
    logic               phaseDone;
    logic               enterTimed;

    function automatic logic isFollow(input mazePkg::carState_t s);
        return s inside {mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT, mazePkg::LITTLE_RIGHT};
    endfunction

    // a done pulse seen during the load cycle belongs to an older phase
    assign phaseDone = timerDone && !timerLoad;

    // checkpoint: any pattern other than the one that brought us here
    assign seenSet = (track != mazePkg::CROSSING) &&
                     !(state == mazePkg::LEFT && track == mazePkg::T_JUNCTION);
    assign groupChange = (stateNext != state) && !(isFollow(state) && isFollow(stateNext));
    assign enterTimed = (stateNext != state) &&
                        (stateNext inside {mazePkg::COUNT, mazePkg::STOP});

    always_comb begin
        stateNext = state;
        resumeNext = resumeState;
        stackCmd = '0;
        case (state)
            mazePkg::IDLE: begin
                if (enable) stateNext = mazePkg::START;
            end
            mazePkg::START: begin
                if (track == mazePkg::ON_LINE) stateNext = mazePkg::COUNT;
            end
            mazePkg::COUNT: begin
                if (phaseDone) stateNext = mazePkg::STRAIGHT;
            end
            mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT, mazePkg::LITTLE_RIGHT: begin
                case (track)
                    mazePkg::OFF_ROAD: begin
                        // dead end, pause then back out
                        stateNext = mazePkg::STOP;
                        resumeNext = mazePkg::BACK;
                    end
                    mazePkg::DRIFT_LEFT, mazePkg::DRIFT_LEFT_HARD: begin
                        stateNext = mazePkg::LITTLE_LEFT;
                    end
                    mazePkg::DRIFT_RIGHT, mazePkg::DRIFT_RIGHT_HARD: begin
                        stateNext = mazePkg::LITTLE_RIGHT;
                    end
                    mazePkg::CROSSING: begin
                        stateNext = seen ? mazePkg::CHOOSE : mazePkg::STRAIGHT;
                        if (seen) begin
                            stackCmd.push = 1'b1;
                            stackCmd.value = mazePkg::GO_STRAIGHT;
                        end
                    end
                    default: begin
                        stateNext = mazePkg::STRAIGHT;
                    end
                endcase
            end
            mazePkg::CHOOSE: begin
                if (track == mazePkg::T_JUNCTION) begin
                    stackCmd = '{push: 1'b1, pop: 1'b1, value: mazePkg::GO_LEFT};
                    stateNext = mazePkg::STOP;
                    resumeNext = mazePkg::LEFT;
                end else if (track == mazePkg::CROSSING && seen) begin
                    stateNext = mazePkg::STRAIGHT;
                end
            end
            mazePkg::LEFT: begin
                if (track == mazePkg::CROSSING && seen) begin
                    stateNext = mazePkg::STOP;
                    resumeNext = mazePkg::STRAIGHT;
                end else if (track == mazePkg::T_JUNCTION && seen) begin
                    stackCmd = '{push: 1'b1, pop: 1'b1, value: mazePkg::GO_RIGHT};
                    stateNext = mazePkg::STOP;
                    resumeNext = mazePkg::RIGHT;
                end
            end
            mazePkg::RIGHT: begin
                if (track == mazePkg::CROSSING && seen) begin
                    stateNext = mazePkg::STOP;
                    resumeNext = mazePkg::STRAIGHT;
                end
            end
            mazePkg::BACK: begin
                if (track == mazePkg::CROSSING) begin
                    // revise the last junction, or drop it if all ways were tried
                    if (top == mazePkg::GO_STRAIGHT) begin
                        stackCmd = '{push: 1'b1, pop: 1'b1, value: mazePkg::GO_LEFT};
                        stateNext = mazePkg::STOP;
                        resumeNext = mazePkg::LEFT;
                    end else if (top == mazePkg::GO_LEFT) begin
                        stackCmd = '{push: 1'b1, pop: 1'b1, value: mazePkg::GO_RIGHT};
                        stateNext = mazePkg::STOP;
                        resumeNext = mazePkg::RIGHT;
                    end else begin
                        stackCmd.pop = 1'b1;
                    end
                end
            end
            mazePkg::STOP: begin
                if (phaseDone) stateNext = resumeState;
            end
            default: begin
                stateNext = state;
            end
        endcase

        if (!enable) begin
            stateNext = mazePkg::IDLE;
            resumeNext = resumeState;
            stackCmd = '0;
        end else if (obstacle && state != mazePkg::IDLE) begin
            stateNext = mazePkg::FINISH;
            resumeNext = resumeState;
            stackCmd = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mazePkg::IDLE;
            resumeState <= mazePkg::STRAIGHT;
            seen <= 1'b0;
            timerLoad <= 1'b0;
            timerCycles <= '0;
        end else begin
            state <= stateNext;
            resumeState <= resumeNext;
            timerLoad <= enterTimed;
            if (enterTimed) begin
                timerCycles <= (stateNext == mazePkg::COUNT) ? mazePkg::START_CYCLES
                                                             : mazePkg::STOP_CYCLES;
            end
            if (groupChange) begin
                seen <= 1'b0;
            end else if (seenSet) begin
                seen <= 1'b1;
            end
        end
    end

    // stack commands come only from states that record or revise junctions
    stackCmdStates: assert property (@(posedge clk) disable iff (rst)
        (stackCmd.push || stackCmd.pop) |->
            state inside {mazePkg::STRAIGHT, mazePkg::LITTLE_LEFT, mazePkg::LITTLE_RIGHT,
                          mazePkg::CHOOSE, mazePkg::LEFT, mazePkg::BACK})
        else $error("stack command in state %s", state.name());

    // the load marks the first cycle of a timed phase
    timerLoadEntry: assert property (@(posedge clk) disable iff (rst)
        timerLoad |-> (state inside {mazePkg::COUNT, mazePkg::STOP}) && state != $past(state))
        else $error("timer load outside phase entry");

endmodule

`default_nettype wire

//--- hdl/mazeCar.sv
`timescale 1ns/1ns
`default_nettype none

module mazeCar (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       enable,
    input  wire                       obstacle,
    input  wire mazePkg::track_t      track,
    output mazePkg::wheelCmd_t        wheels,
    output mazePkg::carState_t        carState,
    output mazePkg::depth_t           stackDepth,
    output mazePkg::decision_t        stackTop
);

    mazePkg::stackCmd_t   stackCmd;
    mazePkg::timerCount_t timerCycles;
    logic                 timerLoad;
    logic                 timerDone;

    routeFsm i_routeFsm (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .obstacle    (obstacle),
        .track       (track),
        .top         (stackTop),
        .timerDone   (timerDone),
        .state       (carState),
        .stackCmd    (stackCmd),
        .timerLoad   (timerLoad),
        .timerCycles (timerCycles)
    );

    decisionStack i_decisionStack (
        .clk      (clk),
        .rst      (rst),
        .stackCmd (stackCmd),
        .top      (stackTop),
        .depth    (stackDepth)
    );

    phaseTimer i_phaseTimer (
        .clk         (clk),
        .rst         (rst),
        .timerLoad   (timerLoad),
        .timerCycles (timerCycles),
        .timerDone   (timerDone)
    );

    motorDrive i_motorDrive (
        .clk    (clk),
        .rst    (rst),
        .state  (carState),
        .wheels (wheels)
    );

endmodule

`default_nettype wire

//--- testbench/mazeCarTb.sv
`timescale 1ns/1ns
`default_nettype none

module mazeCarTb;

    // six tests, each well under 100 cycles, so 2000 leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int CLK_HALF = 4;

    logic               clk;
    logic               rst;
    logic               enable;
    logic               obstacle;
    mazePkg::track_t    track;
    mazePkg::wheelCmd_t wheels;
    mazePkg::carState_t carState;
    mazePkg::depth_t    stackDepth;
    mazePkg::decision_t stackTop;

    int          errorCount = 0;
    int          errorsAtStart = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;
    logic [31:0] lcgState;

    mazeCar i_mazeCar (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .obstacle   (obstacle),
        .track      (track),
        .wheels     (wheels),
        .carState   (carState),
        .stackDepth (stackDepth),
        .stackTop   (stackTop)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with tests unfinished", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            errorCount++;
        end
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // line slid under the left sensor means steer left
    function automatic mazePkg::carState_t driftState(input mazePkg::track_t pattern);
        if (pattern[2]) begin
            return mazePkg::LITTLE_LEFT;
        end else begin
            return mazePkg::LITTLE_RIGHT;
        end
    endfunction

    task automatic waitForState(input mazePkg::carState_t target, input int limit,
                                output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (carState !== target && cycles < limit);
        if (carState !== target) begin
            $display("state %0d was not reached within %0d cycles at %0t ns",
                     target, limit, $time);
            errorCount++;
        end
    endtask

    // high cycles of each PWM output over one full period
    task automatic countPwmHigh(output int leftHigh, output int rightHigh);
        leftHigh = 0;
        rightHigh = 0;
        repeat (mazePkg::PWM_PERIOD) begin
            @(negedge clk);
            leftHigh += wheels.leftPwm;
            rightHigh += wheels.rightPwm;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst = 1'b1;
        enable = 1'b0;
        obstacle = 1'b0;
        track = mazePkg::OFF_ROAD;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // from IDLE on the start line to STRAIGHT
    task automatic startDriving();
        int cycles;
        enable = 1'b1;
        track = mazePkg::ON_LINE;
        waitForState(mazePkg::COUNT, 4, cycles);
        waitForState(mazePkg::STRAIGHT, 40, cycles);
    endtask

    task automatic openTest();
        errorsAtStart = errorCount;
    endtask

    task automatic closeTest(input string name);
        testsRun++;
        if (errorCount == errorsAtStart) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    task automatic resetValues();
        openTest();
        applyReset();
        checkEq(carState, mazePkg::IDLE, "state after reset");
        checkEq(wheels, 32'd0, "wheel bits after reset");
        checkEq(stackDepth, 32'd0, "stack depth after reset");
        checkEq(stackTop, mazePkg::NONE, "stack top after reset");
        closeTest("reset");
    endtask

    task automatic startUpDelay();
        int cycles;
        int leftHigh;
        int rightHigh;
        openTest();
        applyReset();
        enable = 1'b1;
        track = mazePkg::ON_LINE;
        waitForState(mazePkg::COUNT, 4, cycles);
        waitForState(mazePkg::STRAIGHT, 40, cycles);
        checkEq(cycles, mazePkg::START_CYCLES + 1, "cycles from COUNT to STRAIGHT");
        checkEq(wheels.leftFwd, 1'b1, "left forward in STRAIGHT");
        checkEq(wheels.rightFwd, 1'b1, "right forward in STRAIGHT");
        checkEq(wheels.leftRev, 1'b0, "left reverse in STRAIGHT");
        checkEq(wheels.rightRev, 1'b0, "right reverse in STRAIGHT");
        countPwmHigh(leftHigh, rightHigh);
        checkEq(leftHigh, mazePkg::PWM_FULL, "left PWM duty in STRAIGHT");
        checkEq(rightHigh, mazePkg::PWM_FULL, "right PWM duty in STRAIGHT");
        closeTest("start-up");
    endtask

    task automatic driftCorrection();
        int              cycles;
        int              leftHigh;
        int              rightHigh;
        logic [31:0]     r;
        mazePkg::track_t pattern;
        openTest();
        applyReset();
        startDriving();
        repeat (8) begin
            r = nextRandom();
            case (r[17:16])
                2'd0: pattern = 3'b001;
                2'd1: pattern = 3'b011;
                2'd2: pattern = 3'b100;
                default: pattern = 3'b110;
            endcase
            track = pattern;
            @(negedge clk);
            checkEq(carState, driftState(pattern), $sformatf("drift pattern %b", pattern));
        end
        // inner wheel slows on a left correction
        track = 3'b100;
        @(negedge clk);
        checkEq(carState, mazePkg::LITTLE_LEFT, "drift pattern 100 before duty count");
        countPwmHigh(leftHigh, rightHigh);
        checkEq(leftHigh, mazePkg::PWM_SLOW, "left PWM duty in LITTLE_LEFT");
        checkEq(rightHigh, mazePkg::PWM_FULL, "right PWM duty in LITTLE_LEFT");
        // dead end
        track = mazePkg::OFF_ROAD;
        @(negedge clk);
        checkEq(carState, mazePkg::STOP, "dead end enters STOP");
        waitForState(mazePkg::BACK, 20, cycles);
        checkEq(cycles, mazePkg::STOP_CYCLES + 1, "cycles from STOP to BACK");
        checkEq(wheels.leftRev, 1'b1, "left reverse in BACK");
        checkEq(wheels.rightRev, 1'b1, "right reverse in BACK");
        checkEq(wheels.leftFwd, 1'b0, "left forward in BACK");
        checkEq(wheels.rightFwd, 1'b0, "right forward in BACK");
        closeTest("drift correction");
    endtask

    task automatic junctionRecord();
        int cycles;
        openTest();
        applyReset();
        startDriving();
        track = mazePkg::ON_LINE;
        @(negedge clk);
        track = mazePkg::CROSSING;
        @(negedge clk);
        checkEq(carState, mazePkg::CHOOSE, "crossing enters CHOOSE");
        checkEq(stackDepth, 32'd1, "depth after junction push");
        checkEq(stackTop, mazePkg::GO_STRAIGHT, "top after junction push");
        track = mazePkg::T_JUNCTION;
        @(negedge clk);
        checkEq(carState, mazePkg::STOP, "T junction pauses in STOP");
        checkEq(stackDepth, 32'd1, "depth after replace");
        checkEq(stackTop, mazePkg::GO_LEFT, "top after T junction");
        waitForState(mazePkg::LEFT, 20, cycles);
        checkEq(cycles, mazePkg::STOP_CYCLES + 1, "cycles from STOP to LEFT");
        checkEq(wheels.leftRev, 1'b1, "left reverse in LEFT");
        checkEq(wheels.rightFwd, 1'b1, "right forward in LEFT");
        closeTest("junction record");
    endtask

    task automatic backtrackRevision();
        int cycles;
        openTest();
        applyReset();
        startDriving();
        track = mazePkg::ON_LINE;
        @(negedge clk);
        track = mazePkg::CROSSING;
        @(negedge clk);
        checkEq(carState, mazePkg::CHOOSE, "crossing enters CHOOSE");
        // leave the junction straight on
        track = mazePkg::ON_LINE;
        @(negedge clk);
        track = mazePkg::CROSSING;
        @(negedge clk);
        checkEq(carState, mazePkg::STRAIGHT, "second crossing returns to STRAIGHT");
        track = mazePkg::OFF_ROAD;
        @(negedge clk);
        waitForState(mazePkg::BACK, 20, cycles);
        checkEq(stackTop, mazePkg::GO_STRAIGHT, "top before revision");
        checkEq(stackDepth, 32'd1, "depth before revision");
        track = mazePkg::CROSSING;
        @(negedge clk);
        checkEq(carState, mazePkg::STOP, "revision pauses in STOP");
        checkEq(stackTop, mazePkg::GO_LEFT, "top after revision");
        checkEq(stackDepth, 32'd1, "depth after revision");
        waitForState(mazePkg::LEFT, 20, cycles);
        checkEq(cycles, mazePkg::STOP_CYCLES + 1, "cycles from STOP to LEFT");
        closeTest("backtrack revision");
    endtask

    task automatic obstacleAndDisable();
        openTest();
        applyReset();
        startDriving();
        obstacle = 1'b1;
        @(negedge clk);
        checkEq(carState, mazePkg::FINISH, "obstacle enters FINISH");
        checkEq(wheels, 32'd0, "wheel bits in FINISH");
        obstacle = 1'b0;
        @(negedge clk);
        checkEq(carState, mazePkg::FINISH, "FINISH holds after obstacle clears");
        enable = 1'b0;
        @(negedge clk);
        checkEq(carState, mazePkg::IDLE, "disable returns to IDLE");
        closeTest("obstacle and disable");
    endtask

    initial begin
        rst = 1'b1;
        enable = 1'b0;
        obstacle = 1'b0;
        track = mazePkg::OFF_ROAD;
        lcgState = 32'h62aa_05b9;
        resetValues();
        startUpDelay();
        driftCorrection();
        junctionRecord();
        backtrackRevision();
        obstacleAndDisable();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: mazeCar

sources:
  - hdl/mazePkg.sv
  - hdl/phaseTimer.sv
  - hdl/decisionStack.sv
  - hdl/motorDrive.sv
  - hdl/routeFsm.sv
  - hdl/mazeCar.sv
  - target: simulation
    files:
      - testbench/mazeCarTb.sv

//--- verilog.f
hdl/mazePkg.sv
hdl/phaseTimer.sv
hdl/decisionStack.sv
hdl/motorDrive.sv
hdl/routeFsm.sv
hdl/mazeCar.sv
testbench/mazeCarTb.sv
